/* tb.f */
+incdir+include
hw/esp_link_pkg.sv
hw/spi_slave_port.sv
hw/esp_cmd_parser.sv
hw/esp_cmd_regs.sv
hw/flash_spi_master.sv
hw/esp_link_top.sv
test/esp_link_ref.sv
test/tb_esp_link.sv

/* Bender.yml */
package:
  name: esp_link

export_include_dirs:
  - include

sources:
  - hw/esp_link_pkg.sv
  - hw/spi_slave_port.sv
  - hw/esp_cmd_parser.sv
  - hw/esp_cmd_regs.sv
  - hw/flash_spi_master.sv
  - hw/esp_link_top.sv
  - target: test
    files:
      - test/esp_link_ref.sv
      - test/tb_esp_link.sv

/* test/tb_esp_link.sv */
`include "esp_link_params.svh"

module tb_esp_link;
  import esp_link_pkg::*;
  import esp_link_ref::*;

  // SCK half-period in system clocks
  localparam int sck_half = 8;

  logic        clk;
  logic        cass_out_sel_n;
  spi_pins_t   esp_spi;
  logic        flash_so;
  logic        esp_miso;
  flash_pins_t flash;
  led_rgb_t    led;
  logic        error_led;
  rgb888_t     screen_color;
  logic [7:0]  esp_status;
  logic        keyb_pressed;
  logic        cass_in;

  integer seed;
  int     errors;
  int     checks;

  // expected DUT state
  led_rgb_t   exp_led;
  rgb888_t    exp_color;
  logic [7:0] exp_status;
  keyb_rows_t exp_keyb;
  logic       exp_cass;
  logic       exp_error;
  logic       exp_cs_n;
  logic [7:0] last_reply;

  // flash slave model
  logic [7:0] flash_reply;
  logic [7:0] flash_captured;
  int         flash_bits;
  logic       sclk_prev;

  // requests to the compare process
  logic       check_req;
  string      test_name;
  string      byte_name_q[$];
  logic [7:0] byte_exp_q[$];
  logic [7:0] byte_got_q[$];

  esp_link_top i_dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .esp_spi        (esp_spi),
    .flash_so       (flash_so),
    .esp_miso       (esp_miso),
    .flash          (flash),
    .led            (led),
    .error_led      (error_led),
    .screen_color   (screen_color),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .cass_in        (cass_in)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rgb(input string name, input rgb888_t exp, input rgb888_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input led_rgb_t exp, input led_rgb_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic compare_queued_bytes();
    string      name;
    logic [7:0] exp;
    logic [7:0] got;
    while (byte_got_q.size() > 0) begin
      name = byte_name_q.pop_front();
      exp  = byte_exp_q.pop_front();
      got  = byte_got_q.pop_front();
      check_byte(name, exp, got);
    end
  endtask

  // outputs are stable at the falling clock edge
  always @(negedge clk) begin
    if (check_req) begin
      compare_queued_bytes();
      check_led({test_name, " led"}, exp_led, led);
      check_rgb({test_name, " screen_color"}, exp_color, screen_color);
      check_byte({test_name, " esp_status"}, exp_status, esp_status);
      check_bit({test_name, " keyb_pressed"}, keyb_any(exp_keyb), keyb_pressed);
      check_bit({test_name, " cass_in"}, exp_cass, cass_in);
      check_bit({test_name, " error_led"}, exp_error, error_led);
      check_bit({test_name, " flash cs_n"}, exp_cs_n, flash.cs_n);
      check_bit({test_name, " flash sclk"}, 1'b0, flash.sclk);
      check_bit({test_name, " esp_miso"}, 1'b0, esp_miso);
      check_req = 1'b0;
    end
  end

  // so is preloaded with the MSB while deselected and then follows each sclk fall
  always @(posedge clk) begin
    sclk_prev <= flash.sclk;
    if (flash.cs_n === 1'b1) begin
      flash_bits <= 0;
      flash_so   <= flash_reply[7];
    end else if (flash.sclk === 1'b1 && sclk_prev === 1'b0) begin
      flash_captured <= {flash_captured[6:0], flash.si};
      flash_bits     <= flash_bits + 1;
    end else if (flash.sclk === 1'b0 && sclk_prev === 1'b1 && flash_bits < 8) begin
      flash_so <= flash_reply[7 - flash_bits];
    end
  end

  task automatic finish_run();
    $display("summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($random(seed));
  endfunction

  task automatic open_frame();
    @(posedge clk);
    esp_spi.cs_n <= 1'b0;
    repeat (sck_half) @(posedge clk);
  endtask

  task automatic close_frame();
    repeat (sck_half) @(posedge clk);
    esp_spi.cs_n <= 1'b1;
    repeat (sck_half) @(posedge clk);
  endtask

  // MOSI set while SCK is low and MISO read just before SCK rises
  task automatic shift_spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      esp_spi.mosi <= tx[i];
      repeat (sck_half - 2) @(posedge clk);
      @(negedge clk);
      rx[i] = esp_miso;
      @(posedge clk);
      esp_spi.sck <= 1'b1;
      repeat (sck_half) @(posedge clk);
      esp_spi.sck <= 1'b0;
    end
  endtask

  task automatic model_command(input logic [7:0] opcode, input logic [7:0] p0,
                               input logic [7:0] p1, input logic [7:0] p2);
    case (opcode)
      cmd_set_led:          exp_led = led_from_param(p0);
      cmd_set_screen_color: exp_color = color_from_params(p0, p1, p2);
      cmd_send_keyb:        exp_keyb = keyb_write(exp_keyb, p0, p1);
      cmd_set_esp_status:   exp_status = p0;
      cmd_set_cass_in:      exp_cass = 1'b1;
      cmd_set_spi_ctrl_reg: exp_cs_n = ~p0[7];
      default: begin
      end
    endcase
    if (param_bytes(opcode) < 0) begin
      exp_error = 1'b1;
    end
    last_reply = expected_reply(opcode, flash_reply, last_reply);
  endtask

  // first_rx is what came back during the opcode byte
  task automatic send_command(input logic [7:0] opcode, input logic [7:0] p0,
                              input logic [7:0] p1, input logic [7:0] p2,
                              output logic [7:0] first_rx);
    logic [7:0] params [3];
    logic [7:0] rx;
    params[0] = p0;
    params[1] = p1;
    params[2] = p2;
    shift_spi_byte(opcode, first_rx);
    for (int k = 0; k < param_bytes(opcode); k++) begin
      shift_spi_byte(params[k], rx);
    end
    model_command(opcode, p0, p1, p2);
  endtask

  task automatic expect_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    byte_name_q.push_back(name);
    byte_exp_q.push_back(exp);
    byte_got_q.push_back(got);
  endtask

  task automatic request_check(input string name);
    int n;
    test_name = name;
    check_req = 1'b1;
    n = 0;
    while (check_req && n < 4) begin
      @(posedge clk);
      n++;
    end
    if (check_req) begin
      report_timeout("the compare process");
    end
  endtask

  task automatic wait_flash_done();
    int n;
    n = 0;
    while (!(flash_bits == 8 && flash.sclk === 1'b0) && n < 12 * `FLASH_CLKS_PER_BIT) begin
      @(posedge clk);
      n++;
    end
    if (!(flash_bits == 8 && flash.sclk === 1'b0)) begin
      report_timeout("eight flash sclk pulses");
    end
  endtask

  task automatic cookie_and_version();
    logic [7:0] rx;
    logic [7:0] exp;
    open_frame();
    send_command(cmd_get_cookie, 8'h00, 8'h00, 8'h00, rx);
    exp = last_reply;
    send_command(cmd_get_version, 8'h00, 8'h00, 8'h00, rx);
    expect_byte("get_cookie reply", exp, rx);
    exp = last_reply;
    send_command(cmd_get_cookie, 8'h00, 8'h00, 8'h00, rx);
    expect_byte("get_version reply", exp, rx);
    close_frame();
    request_check("cookie_version");
  endtask

  task automatic register_writes();
    logic [7:0] rx;
    open_frame();
    send_command(cmd_set_led, rand_byte(), 8'h00, 8'h00, rx);
    send_command(cmd_set_screen_color, rand_byte(), rand_byte(), rand_byte(), rx);
    send_command(cmd_set_esp_status, rand_byte(), 8'h00, 8'h00, rx);
    close_frame();
    request_check("register_writes");
  endtask

  task automatic keyboard_rows();
    logic [7:0] rx;
    logic [7:0] row;
    logic [7:0] val;
    row = rand_byte();
    val = rand_byte();
    if (val == 8'h00) begin
      val = 8'h01;
    end
    open_frame();
    send_command(cmd_send_keyb, row, val, 8'h00, rx);
    close_frame();
    request_check("keyb_press");
    open_frame();
    send_command(cmd_send_keyb, row, 8'h00, 8'h00, rx);
    close_frame();
    request_check("keyb_release");
  endtask

  task automatic flash_transfer();
    logic [7:0] rx;
    logic [7:0] tx;
    logic [7:0] exp;
    flash_reply = rand_byte();
    tx = rand_byte();
    open_frame();
    send_command(cmd_set_spi_ctrl_reg, 8'h80, 8'h00, 8'h00, rx);
    close_frame();
    request_check("flash_select");
    open_frame();
    send_command(cmd_set_spi_data, tx, 8'h00, 8'h00, rx);
    close_frame();
    wait_flash_done();
    expect_byte("flash si byte", tx, flash_captured);
    open_frame();
    send_command(cmd_get_spi_data, 8'h00, 8'h00, 8'h00, rx);
    exp = last_reply;
    send_command(cmd_get_cookie, 8'h00, 8'h00, 8'h00, rx);
    expect_byte("get_spi_data reply", exp, rx);
    send_command(cmd_set_spi_ctrl_reg, 8'h00, 8'h00, 8'h00, rx);
    close_frame();
    request_check("flash_transfer");
  endtask

  task automatic bad_opcode();
    logic [7:0] rx;
    logic [7:0] exp;
    open_frame();
    // version reply first so the cookie reply after the error is a fresh one
    send_command(cmd_get_version, 8'h00, 8'h00, 8'h00, rx);
    send_command(8'h40, 8'h00, 8'h00, 8'h00, rx);
    send_command(cmd_set_cass_in, 8'h00, 8'h00, 8'h00, rx);
    send_command(cmd_get_cookie, 8'h00, 8'h00, 8'h00, rx);
    exp = last_reply;
    send_command(cmd_get_cookie, 8'h00, 8'h00, 8'h00, rx);
    expect_byte("cookie after error", exp, rx);
    close_frame();
    request_check("bad_opcode");
  endtask

  initial begin
    seed           = 75;
    errors         = 0;
    checks         = 0;
    check_req      = 1'b0;
    cass_out_sel_n = 1'b0;
    esp_spi        = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    flash_so       = 1'b0;
    flash_reply    = 8'h00;
    flash_captured = 8'h00;
    flash_bits     = 0;
    sclk_prev      = 1'b0;
    exp_led        = '0;
    exp_color      = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
    exp_status     = 8'h00;
    exp_keyb       = '0;
    exp_cass       = 1'b0;
    exp_error      = 1'b0;
    exp_cs_n       = 1'b1;
    last_reply     = 8'h00;
    repeat (4) @(posedge clk);
    cass_out_sel_n <= 1'b1;
    repeat (2) @(posedge clk);
    request_check("reset");
    cookie_and_version();
    register_writes();
    keyboard_rows();
    flash_transfer();
    bad_opcode();
    finish_run();
  end

endmodule

/* test/esp_link_ref.sv */
package esp_link_ref;
  import esp_link_pkg::*;

  typedef logic [7:0][7:0] keyb_rows_t;

  // byte the ESP reads during the byte after a command
  function automatic logic [7:0] expected_reply(input logic [7:0] opcode,
                                                input logic [7:0] flash_byte,
                                                input logic [7:0] prev);
    case (opcode)
      8'd0:    return 8'hAF;
      8'd15:   return 8'h03;
      8'd31:   return flash_byte;
      default: return prev;
    endcase
  endfunction

  // parameter bytes per opcode, -1 for an unknown opcode
  function automatic int param_bytes(input logic [7:0] opcode);
    case (opcode)
      8'd0, 8'd15, 8'd28, 8'd31: return 0;
      8'd26, 8'd29, 8'd30, 8'd32: return 1;
      8'd19:   return 2;
      8'd17:   return 3;
      default: return -1;
    endcase
  endfunction

  function automatic led_rgb_t led_from_param(input logic [7:0] p0);
    led_rgb_t led;
    led.red   = p0[0];
    led.green = p0[1];
    led.blue  = p0[2];
    return led;
  endfunction

  function automatic rgb888_t color_from_params(input logic [7:0] p0, input logic [7:0] p1,
                                                input logic [7:0] p2);
    rgb888_t color;
    color.red   = p0;
    color.green = p1;
    color.blue  = p2;
    return color;
  endfunction

  // row number sits in the low 3 bits of p0
  function automatic keyb_rows_t keyb_write(input keyb_rows_t rows, input logic [7:0] p0,
                                            input logic [7:0] p1);
    keyb_rows_t next;
    next = rows;
    next[p0[2:0]] = p1;
    return next;
  endfunction

  function automatic logic keyb_any(input keyb_rows_t rows);
    logic any;
    any = 1'b0;
    for (int r = 0; r < 8; r++) begin
      any = any | (rows[r] != 8'h00);
    end
    return any;
  endfunction

endpackage

/* hw/esp_link_top.sv */
module esp_link_top (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  esp_link_pkg::spi_pins_t   esp_spi,
  input  logic                      flash_so,
  output logic                      esp_miso,
  output esp_link_pkg::flash_pins_t flash,
  output esp_link_pkg::led_rgb_t    led,
  output logic                      error_led,
  output esp_link_pkg::rgb888_t     screen_color,
  output logic [7:0]                esp_status,
  output logic                      keyb_pressed,
  output logic                      cass_in
);
  import esp_link_pkg::*;

  logic [7:0] rx_byte;
  logic       rx_valid;
  esp_cmd_t   cmd;
  logic       cmd_valid;
  logic [7:0] reply_byte;
  logic       flash_start;
  logic [7:0] flash_tx_byte;
  logic       flash_sel;
  logic [7:0] flash_rx_byte;
  logic       flash_busy;

  spi_slave_port i_spi_slave_port (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .pins           (esp_spi),
    .reply_byte     (reply_byte),
    .miso           (esp_miso),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid)
  );

  esp_cmd_parser i_esp_cmd_parser (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .cmd_error      (error_led)
  );

  esp_cmd_regs i_esp_cmd_regs (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .flash_rx_byte  (flash_rx_byte),
    .flash_busy     (flash_busy),
    .led            (led),
    .screen_color   (screen_color),
    .esp_status     (esp_status),
    .keyb_pressed   (keyb_pressed),
    .cass_in        (cass_in),
    .flash_sel      (flash_sel),
    .flash_start    (flash_start),
    .flash_tx_byte  (flash_tx_byte),
    .reply_byte     (reply_byte)
  );

  flash_spi_master i_flash_spi_master (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .start          (flash_start),
    .tx_byte        (flash_tx_byte),
    .flash_sel      (flash_sel),
    .so             (flash_so),
    .pins           (flash),
    .rx_byte        (flash_rx_byte),
    .busy           (flash_busy)
  );

endmodule

/* hw/flash_spi_master.sv */
`include "esp_link_params.svh"

module flash_spi_master (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      start,
  input  logic [7:0]                tx_byte,
  input  logic                      flash_sel,
  input  logic                      so,
  output esp_link_pkg::flash_pins_t pins,
  output logic [7:0]                rx_byte,
  output logic                      busy
);

  localparam int phase_w = $clog2(`FLASH_CLKS_PER_BIT);
  localparam int cnt_w   = phase_w + 3;
  localparam int half    = `FLASH_CLKS_PER_BIT / 2;

  logic [cnt_w-1:0]   cnt_q;
  logic [phase_w-1:0] phase;
  logic [7:0]         shift_q;
  logic               si_q;
  logic               sclk;

  // position inside the current bit
  assign phase = cnt_q[phase_w-1:0];

  // high for the second half of every bit
  assign sclk = busy & (phase >= phase_w'(half));

  assign pins    = '{cs_n: ~flash_sel, sclk: sclk, si: si_q};
  assign rx_byte = shift_q;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      busy    <= 1'b0;
      cnt_q   <= '0;
      shift_q <= 8'h00;
      si_q    <= 1'b0;
    end else if (busy) begin
      cnt_q <= cnt_q + 1'b1;
      if (phase == '0) begin
        // next bit out while sclk is low
        si_q <= shift_q[7];
      end else if (phase == phase_w'(half)) begin
        // sample on the sclk rising edge
        shift_q <= {shift_q[6:0], so};
      end
      if (cnt_q == '1) begin
        busy <= 1'b0;
      end
    end else if (start) begin
      // a start while busy never reaches this branch
      busy    <= 1'b1;
      cnt_q   <= '0;
      shift_q <= tx_byte;
    end
  end

endmodule

/* hw/esp_cmd_regs.sv */
`include "esp_link_params.svh"

module esp_cmd_regs (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  esp_link_pkg::esp_cmd_t cmd,
  input  logic                   cmd_valid,
  input  logic [7:0]             flash_rx_byte,
  input  logic                   flash_busy,
  output esp_link_pkg::led_rgb_t led,
  output esp_link_pkg::rgb888_t  screen_color,
  output logic [7:0]             esp_status,
  output logic                   keyb_pressed,
  output logic                   cass_in,
  output logic                   flash_sel,
  output logic                   flash_start,
  output logic [7:0]             flash_tx_byte,
  output logic [7:0]             reply_byte
);
  import esp_link_pkg::*;

  localparam int row_w = $clog2(`KEYB_ROWS);

  logic [`KEYB_ROWS-1:0][7:0] keyb_q;
  logic [row_w-1:0]           keyb_row;

  assign keyb_row = cmd.p0[row_w-1:0];

  // any key down in any row
  assign keyb_pressed = |keyb_q;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led           <= '0;
      screen_color  <= '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
      esp_status    <= 8'h00;
      keyb_q        <= '0;
      cass_in       <= 1'b0;
      flash_sel     <= 1'b0;
      flash_start   <= 1'b0;
      flash_tx_byte <= 8'h00;
      reply_byte    <= 8'h00;
    end else begin
      flash_start <= 1'b0;
      if (cmd_valid) begin
        case (cmd.opcode)
          cmd_set_led: begin
            led <= '{red: cmd.p0[0], green: cmd.p0[1], blue: cmd.p0[2]};
          end
          cmd_set_screen_color: begin
            screen_color <= '{red: cmd.p0, green: cmd.p1, blue: cmd.p2};
          end
          cmd_send_keyb: begin
            keyb_q[keyb_row] <= cmd.p1;
          end
          cmd_set_esp_status: begin
            esp_status <= cmd.p0;
          end
          cmd_set_cass_in: begin
            cass_in <= 1'b1;
          end
          // only the chip-select bit of the control byte is wired out
          cmd_set_spi_ctrl_reg: begin
            flash_sel <= cmd.p0[7];
          end
          cmd_set_spi_data: begin
            if (!flash_busy) begin
              flash_start   <= 1'b1;
              flash_tx_byte <= cmd.p0;
            end
          end
          // reply goes out during the next ESP byte
          cmd_get_cookie: begin
            reply_byte <= `ESP_COOKIE;
          end
          cmd_get_version: begin
            reply_byte <= {`ESP_VERSION_MAJOR, `ESP_VERSION_MINOR};
          end
          cmd_get_spi_data: begin
            reply_byte <= flash_rx_byte;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

/* hw/esp_cmd_parser.sv */
module esp_cmd_parser (
  input  logic                   clk,
  input  logic                   cass_out_sel_n,
  input  logic [7:0]             rx_byte,
  input  logic                   rx_valid,
  output esp_link_pkg::esp_cmd_t cmd,
  output logic                   cmd_valid,
  output logic                   cmd_error
);
  import esp_link_pkg::*;

  typedef enum logic {
    st_idle,
    st_collect
  } state_e;

  state_e                 state_q;
  logic [param_cnt_w-1:0] param_total_q;
  logic [param_cnt_w-1:0] param_idx_q;
  logic [param_cnt_w-1:0] op_count;
  logic                   op_unknown;

  // lookup for the byte on rx_byte, only meaningful in idle
  always_comb begin
    op_count = esp_param_count(rx_byte, op_unknown);
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state_q       <= st_idle;
      param_total_q <= '0;
      param_idx_q   <= '0;
      cmd           <= '0;
      cmd_valid     <= 1'b0;
      cmd_error     <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state_q)
          st_idle: begin
            if (op_unknown) begin
              // sticky, the byte itself is dropped
              cmd_error <= 1'b1;
            end else begin
              cmd.opcode    <= esp_cmd_e'(rx_byte);
              param_total_q <= op_count;
              param_idx_q   <= '0;
              if (op_count == param_cnt_w'(0)) begin
                cmd_valid <= 1'b1;
              end else begin
                state_q <= st_collect;
              end
            end
          end
          st_collect: begin
            case (param_idx_q)
              param_cnt_w'(0): cmd.p0 <= rx_byte;
              param_cnt_w'(1): cmd.p1 <= rx_byte;
              default:         cmd.p2 <= rx_byte;
            endcase
            param_idx_q <= param_idx_q + 1'b1;
            // last parameter completes the command
            if (param_idx_q == param_total_q - 1'b1) begin
              cmd_valid <= 1'b1;
              state_q   <= st_idle;
            end
          end
          default: begin
            state_q <= st_idle;
          end
        endcase
      end
    end
  end

endmodule

/* hw/spi_slave_port.sv */
`include "esp_link_params.svh"

module spi_slave_port (
  input  logic                    clk,
  input  logic                    cass_out_sel_n,
  input  esp_link_pkg::spi_pins_t pins,
  input  logic [7:0]              reply_byte,
  output logic                    miso,
  output logic [7:0]              rx_byte,
  output logic                    rx_valid
);
  import esp_link_pkg::*;

  // bus idle state, SCK low and CS high
  localparam spi_pins_t pins_idle = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  spi_pins_t [`ESP_SYNC_STAGES-1:0] sync_q;
  spi_pins_t                        pins_s;
  logic                             sck_prev_q;
  logic                             sck_rise;
  logic                             sck_fall;
  logic                             cs_active;
  logic [2:0]                       bit_cnt_q;
  logic [7:0]                       tx_shift_q;

  assign pins_s    = sync_q[`ESP_SYNC_STAGES-1];
  assign cs_active = ~pins_s.cs_n;
  assign sck_rise  = pins_s.sck & ~sck_prev_q;
  assign sck_fall  = ~pins_s.sck & sck_prev_q;

  // low while not selected
  assign miso = cs_active & tx_shift_q[7];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sync_q     <= {`ESP_SYNC_STAGES{pins_idle}};
      sck_prev_q <= 1'b0;
    end else begin
      sync_q     <= {sync_q[`ESP_SYNC_STAGES-2:0], pins};
      sck_prev_q <= pins_s.sck;
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt_q  <= 3'd0;
      rx_byte    <= 8'h00;
      rx_valid   <= 1'b0;
      tx_shift_q <= 8'h00;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt_q  <= 3'd0;
        tx_shift_q <= 8'h00;
      end else begin
        // master drives MOSI before the rising edge, MSB first
        if (sck_rise) begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          rx_byte   <= {rx_byte[6:0], pins_s.mosi};
          if (bit_cnt_q == 3'd7) begin
            rx_valid <= 1'b1;
          end
        end
        // count is zero only on the falling edge right after a full byte
        if (sck_fall) begin
          if (bit_cnt_q == 3'd0) begin
            tx_shift_q <= reply_byte;
          end else begin
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};
          end
        end
      end
    end
  end

endmodule

/* hw/esp_link_pkg.sv */
`include "esp_link_params.svh"

package esp_link_pkg;

  // opcodes the ESP may send
  typedef enum logic [7:0] {
    cmd_get_cookie       = 8'd0,
    cmd_get_version      = 8'd15,
    cmd_set_screen_color = 8'd17,
    cmd_send_keyb        = 8'd19,
    cmd_set_led          = 8'd26,
    cmd_set_cass_in      = 8'd28,
    cmd_set_spi_ctrl_reg = 8'd29,
    cmd_set_spi_data     = 8'd30,
    cmd_get_spi_data     = 8'd31,
    cmd_set_esp_status   = 8'd32
  } esp_cmd_e;

  // one complete command, parameters in arrival order
  typedef struct packed {
    esp_cmd_e   opcode;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
  } esp_cmd_t;

  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  typedef struct packed {
    logic cs_n;
    logic sclk;
    logic si;
  } flash_pins_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_rgb_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb888_t;

  localparam int param_cnt_w = $clog2(`ESP_MAX_PARAMS + 1);

  // parameter bytes that follow an opcode
  function automatic logic [param_cnt_w-1:0] esp_param_count(input logic [7:0] opcode,
                                                             output logic unknown);
    unknown = 1'b0;
    case (opcode)
      cmd_get_cookie, cmd_get_version, cmd_set_cass_in, cmd_get_spi_data:
        esp_param_count = param_cnt_w'(0);
      cmd_set_led, cmd_set_spi_ctrl_reg, cmd_set_spi_data, cmd_set_esp_status:
        esp_param_count = param_cnt_w'(1);
      cmd_send_keyb:
        esp_param_count = param_cnt_w'(2);
      cmd_set_screen_color:
        esp_param_count = param_cnt_w'(3);
      default: begin
        esp_param_count = param_cnt_w'(0);
        unknown = 1'b1;
      end
    endcase
  endfunction

endpackage

/* include/esp_link_params.svh */
`ifndef ESP_LINK_PARAMS_SVH
`define ESP_LINK_PARAMS_SVH

// reply to get_cookie, lets the ESP detect the FPGA
`define ESP_COOKIE 8'hAF

// get_version reply is {major, minor}
`define ESP_VERSION_MAJOR 3'd0
`define ESP_VERSION_MINOR 5'd3

// flops on the ESP serial pins
`define ESP_SYNC_STAGES 2

// flash serial clock period in system clocks
`define FLASH_CLKS_PER_BIT 16

// keyboard matrix rows
`define KEYB_ROWS 8

// longest parameter list of any command
`define ESP_MAX_PARAMS 3

`endif
